// ==== dec_out.sv ====
`timescale 1ns/10ps

module dec_out import isa_pkg::*, mem_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // from fetch and decode
    input  logic       inst_valid_i,
    output logic       inst_take_o,
    input  addr_t      inst_pc_i,
    input  opinfo_t    opinfo_i,
    input  alu_op_t    alu_i,
    input  branch_op_t branch_i,
    input  load_op_t   load_i,
    input  store_op_t  store_i,
    input  sys_op_t    sys_i,
    input  csr_op_t    csr_i,
    input  logic       wen_reg_i,
    input  logic       wen_csr_i,
    input  reg_idx_t   rd_i,
    input  reg_idx_t   rs1_i,
    input  reg_idx_t   rs2_i,
    input  imm_t       imm_i,
    input  logic       is_load_signed_i,
    input  logic       wen_mem_i,
    input  logic       ren_mem_i,
    input  mask_t      mask_i,

    // registered decode towards the back end
    output opinfo_t    opinfo_o,
    output alu_op_t    alu_o,
    output branch_op_t branch_o,
    output load_op_t   load_o,
    output store_op_t  store_o,
    output sys_op_t    sys_o,
    output csr_op_t    csr_o,
    output logic       wen_reg_o,
    output logic       wen_csr_o,
    output reg_idx_t   rd_o,
    output reg_idx_t   rs1_o,
    output reg_idx_t   rs2_o,
    output imm_t       imm_o,
    output logic       is_load_signed_o,
    output logic       wen_mem_o,
    output logic       ren_mem_o,
    output mask_t      mask_o,
    output addr_t      pc_o,
    output logic       valid_o,
    input  logic       ready_i
);

    logic load_en;

    // slot is free or drains on this edge
    assign inst_take_o = ~valid_o | ready_i;
    assign load_en     = inst_valid_i & inst_take_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (load_en) begin
            valid_o <= 1'b1;
        end else if (ready_i) begin
            valid_o <= 1'b0;
        end
    end

    // payload holds while stalled
    always_ff @(posedge clk_i) begin
        if (load_en) begin
            opinfo_o         <= opinfo_i;
            alu_o            <= alu_i;
            branch_o         <= branch_i;
            load_o           <= load_i;
            store_o          <= store_i;
            sys_o            <= sys_i;
            csr_o            <= csr_i;
            wen_reg_o        <= wen_reg_i;
            wen_csr_o        <= wen_csr_i;
            rd_o             <= rd_i;
            rs1_o            <= rs1_i;
            rs2_o            <= rs2_i;
            imm_o            <= imm_i;
            is_load_signed_o <= is_load_signed_i;
            wen_mem_o        <= wen_mem_i;
            ren_mem_o        <= ren_mem_i;
            mask_o           <= mask_i;
            pc_o             <= inst_pc_i;
        end
    end

endmodule

// ==== decode_top.sv ====
`timescale 1ns/10ps

module decode_top import isa_pkg::*, mem_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // instruction fetch bus
    output logic       wb_cyc_o,
    output logic       wb_stb_o,
    output logic       wb_we_o,
    output addr_t      wb_adr_o,
    input  inst_t      wb_dat_i,
    input  logic       wb_ack_i,

    // decoded instruction stream
    output opinfo_t    opinfo_o,
    output alu_op_t    alu_o,
    output branch_op_t branch_o,
    output load_op_t   load_o,
    output store_op_t  store_o,
    output sys_op_t    sys_o,
    output csr_op_t    csr_o,
    output logic       wen_reg_o,
    output logic       wen_csr_o,
    output reg_idx_t   rd_o,
    output reg_idx_t   rs1_o,
    output reg_idx_t   rs2_o,
    output imm_t       imm_o,
    output logic       is_load_signed_o,
    output logic       wen_mem_o,
    output logic       ren_mem_o,
    output mask_t      mask_o,
    output addr_t      pc_o,
    output logic       valid_o,
    input  logic       ready_i
);

    // fetch to decode hand-off
    logic       inst_valid;
    logic       inst_take;
    inst_t      inst;
    addr_t      inst_pc;

    // combinational decode results
    opinfo_t    dec_opinfo;
    alu_op_t    dec_alu;
    branch_op_t dec_branch;
    load_op_t   dec_load;
    store_op_t  dec_store;
    sys_op_t    dec_sys;
    csr_op_t    dec_csr;
    logic       dec_wen_reg;
    logic       dec_wen_csr;
    reg_idx_t   dec_rd;
    reg_idx_t   dec_rs1;
    reg_idx_t   dec_rs2;
    imm_t       dec_imm;
    logic       dec_load_signed;
    logic       dec_wen_mem;
    logic       dec_ren_mem;
    mask_t      dec_mask;

    ifu i_ifu (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .inst_pc_o    (inst_pc),
        .inst_take_i  (inst_take)
    );

    idu i_idu (
        .inst_i           (inst),
        .opinfo_o         (dec_opinfo),
        .alu_o            (dec_alu),
        .branch_o         (dec_branch),
        .load_o           (dec_load),
        .store_o          (dec_store),
        .sys_o            (dec_sys),
        .csr_o            (dec_csr),
        .wen_reg_o        (dec_wen_reg),
        .wen_csr_o        (dec_wen_csr),
        .rd_o             (dec_rd),
        .rs1_o            (dec_rs1),
        .rs2_o            (dec_rs2),
        .imm_o            (dec_imm),
        .is_load_signed_o (dec_load_signed),
        .wen_mem_o        (dec_wen_mem),
        .ren_mem_o        (dec_ren_mem),
        .mask_o           (dec_mask)
    );

    dec_out i_dec_out (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .inst_valid_i (inst_valid), .inst_take_o (inst_take), .inst_pc_i (inst_pc),
        .opinfo_i (dec_opinfo), .alu_i (dec_alu), .branch_i (dec_branch),
        .load_i (dec_load), .store_i (dec_store), .sys_i (dec_sys), .csr_i (dec_csr),
        .wen_reg_i (dec_wen_reg), .wen_csr_i (dec_wen_csr),
        .rd_i (dec_rd), .rs1_i (dec_rs1), .rs2_i (dec_rs2), .imm_i (dec_imm),
        .is_load_signed_i (dec_load_signed), .wen_mem_i (dec_wen_mem),
        .ren_mem_i (dec_ren_mem), .mask_i (dec_mask),
        .opinfo_o (opinfo_o), .alu_o (alu_o), .branch_o (branch_o),
        .load_o (load_o), .store_o (store_o), .sys_o (sys_o), .csr_o (csr_o),
        .wen_reg_o (wen_reg_o), .wen_csr_o (wen_csr_o),
        .rd_o (rd_o), .rs1_o (rs1_o), .rs2_o (rs2_o), .imm_o (imm_o),
        .is_load_signed_o (is_load_signed_o), .wen_mem_o (wen_mem_o),
        .ren_mem_o (ren_mem_o), .mask_o (mask_o),
        .pc_o    (pc_o),
        .valid_o (valid_o),
        .ready_i (ready_i)
    );

endmodule

// ==== filelist.f ====
isa_pkg.sv
mem_pkg.sv
igu.sv
idu.sv
ifu.sv
dec_out.sv
decode_top.sv
tb_checker.sv
tb_decode.sv

// ==== idu.sv ====
`timescale 1ns/10ps

module idu import isa_pkg::*, mem_pkg::*; (
    input  inst_t      inst_i,

    output opinfo_t    opinfo_o,
    output alu_op_t    alu_o,
    output branch_op_t branch_o,
    output load_op_t   load_o,
    output store_op_t  store_o,
    output sys_op_t    sys_o,
    output csr_op_t    csr_o,

    output logic       wen_reg_o,
    output logic       wen_csr_o,
    output reg_idx_t   rd_o,
    output reg_idx_t   rs1_o,
    output reg_idx_t   rs2_o,
    output imm_t       imm_o,

    output logic       is_load_signed_o,
    output logic       wen_mem_o,
    output logic       ren_mem_o,
    output mask_t      mask_o
);

    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    funct12_t funct12;
    logic [7:0] f3_hot;
    imm_sel_t imm_sel;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign funct12 = inst_i[31:20];
    assign rd_o    = inst_i[11:7];
    assign rs1_o   = inst_i[19:15];
    assign rs2_o   = inst_i[24:20];

    // funct3 as one-hot, indexed by its value
    assign f3_hot = 8'b1 << funct3;

    // instruction class
    wire is_alu    = (opcode == OP_ALU);
    wire is_alui   = (opcode == OP_ALUI);
    wire is_aluw   = (opcode == OP_ALUW);
    wire is_aluiw  = (opcode == OP_ALUIW);
    wire is_branch = (opcode == OP_BRANCH);
    wire is_jal    = (opcode == OP_JAL);
    wire is_jalr   = (opcode == OP_JALR);
    wire is_load   = (opcode == OP_LOAD);
    wire is_store  = (opcode == OP_STORE);
    wire is_lui    = (opcode == OP_LUI);
    wire is_auipc  = (opcode == OP_AUIPC);
    // sys and csr sit on the same opcode
    wire is_system = (opcode == OP_SYSTEM);

    wire f7_base   = (funct7 == F7_BASE);
    wire f7_alt    = (funct7 == F7_ALT);
    wire f7_muldiv = (funct7 == F7_MULDIV);

    // register forms, immediate forms, and all four for shifts
    wire reg_form  = is_alu | is_aluw;
    wire imm_form  = is_alui | is_aluiw;
    wire any_alu   = reg_form | imm_form;

    assign opinfo_o = {
        is_system,
        is_system,
        is_auipc,
        is_lui,
        is_store,
        is_load,
        is_jalr,
        is_jal,
        is_branch,
        is_aluiw,
        is_aluw,
        is_alui,
        is_alu
    };

    // word and immediate variants fold into the base op bit
    wire op_add  = (reg_form & f3_hot[0] & f7_base) | (imm_form & f3_hot[0]);
    wire op_sub  = reg_form & f3_hot[0] & f7_alt;
    wire op_xor  = (is_alu & f3_hot[4] & f7_base) | (is_alui & f3_hot[4]);
    wire op_or   = (is_alu & f3_hot[6] & f7_base) | (is_alui & f3_hot[6]);
    wire op_and  = (is_alu & f3_hot[7] & f7_base) | (is_alui & f3_hot[7]);
    wire op_sll  = any_alu & f3_hot[1] & f7_base;
    wire op_srl  = any_alu & f3_hot[5] & f7_base;
    wire op_sra  = any_alu & f3_hot[5] & f7_alt;
    wire op_slt  = (is_alu & f3_hot[2] & f7_base) | (is_alui & f3_hot[2]);
    wire op_sltu = (is_alu & f3_hot[3] & f7_base) | (is_alui & f3_hot[3]);

    // mul through remu follow funct3 order directly
    assign alu_o = {
        {8{is_alu & f7_muldiv}} & f3_hot,
        op_sltu,
        op_slt,
        op_sra,
        op_srl,
        op_sll,
        op_and,
        op_or,
        op_xor,
        op_sub,
        op_add
    };

    // funct3 2 and 3 are unused for branches
    assign branch_o = {6{is_branch}} & {f3_hot[7:4], f3_hot[1:0]};
    assign load_o   = {7{is_load}} & f3_hot[6:0];
    assign store_o  = {4{is_store}} & f3_hot[3:0];

    assign sys_o = {
        is_system & f3_hot[0] & (funct12 == F12_MRET),
        is_system & f3_hot[0] & (funct12 == F12_ECALL),
        is_system & f3_hot[0] & (funct12 == F12_EBREAK)
    };
    assign csr_o = {2{is_system}} & f3_hot[2:1];

    assign wen_reg_o = ~(is_branch | is_store | is_system);
    assign wen_csr_o = is_system;

    // system words also take the I layout for the csr address
    assign imm_sel = {
        is_jal,
        is_lui | is_auipc,
        is_branch,
        is_store,
        is_alui | is_aluiw | is_load | is_jalr | is_system
    };

    igu i_igu (
        .imm_sel_i (imm_sel),
        .inst_i    (inst_i),
        .imm_o     (imm_o)
    );

    // memory side
    wire size_byte   = load_o[0] | load_o[4] | store_o[0];
    wire size_half   = load_o[1] | load_o[5] | store_o[1];
    wire size_word   = load_o[2] | load_o[6] | store_o[2];
    wire size_double = load_o[3] | store_o[3];

    assign is_load_signed_o = |load_o[3:0];
    assign ren_mem_o        = is_load;
    assign wen_mem_o        = is_store;

    assign mask_o = ({MASK_W{size_byte}}   & MASK_BYTE)
                  | ({MASK_W{size_half}}   & MASK_HALF)
                  | ({MASK_W{size_word}}   & MASK_WORD)
                  | ({MASK_W{size_double}} & MASK_DOUBLE);

endmodule

// ==== ifu.sv ====
`timescale 1ns/10ps

module ifu import isa_pkg::*, mem_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,

    // wishbone classic fetch master
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output addr_t wb_adr_o,
    input  inst_t wb_dat_i,
    input  logic  wb_ack_i,

    // fetched word towards decode
    output logic  inst_valid_o,
    output inst_t inst_o,
    output addr_t inst_pc_o,
    input  logic  inst_take_i
);

    typedef enum logic {
        S_IDLE,
        S_REQ
    } state_t;

    state_t state_q;
    state_t state_d;
    addr_t  pc_q;
    logic   hold_valid_q;
    logic   room;
    logic   ack_hit;

    // holding register is empty or leaves this cycle
    assign room    = ~hold_valid_q | inst_take_i;
    assign ack_hit = (state_q == S_REQ) & wb_ack_i;

    assign wb_cyc_o     = (state_q == S_REQ);
    assign wb_stb_o     = (state_q == S_REQ);
    assign wb_we_o      = 1'b0;
    assign wb_adr_o     = pc_q;
    assign inst_valid_o = hold_valid_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (room) begin
                    state_d = S_REQ;
                end
            end
            S_REQ: begin
                // strobes drop in the cycle after ack
                if (wb_ack_i) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= S_IDLE;
            pc_q         <= RESET_PC;
            hold_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (ack_hit) begin
                pc_q         <= pc_q + addr_t'(INST_BYTES);
                hold_valid_q <= 1'b1;
            end else if (inst_take_i) begin
                hold_valid_q <= 1'b0;
            end
        end
    end

    // returned word and the address it came from
    always_ff @(posedge clk_i) begin
        if (ack_hit) begin
            inst_o    <= wb_dat_i;
            inst_pc_o <= pc_q;
        end
    end

endmodule

// ==== igu.sv ====
`timescale 1ns/10ps

module igu import isa_pkg::*; (
    input  imm_sel_t imm_sel_i,
    input  inst_t    inst_i,
    output imm_t     imm_o
);

    logic sign;
    imm_t fmt_i;
    imm_t fmt_s;
    imm_t fmt_b;
    imm_t fmt_u;
    imm_t fmt_j;

    // every format takes its sign from bit 31
    assign sign = inst_i[31];

    assign fmt_i = {{(IMM_W-12){sign}}, inst_i[31:20]};
    assign fmt_s = {{(IMM_W-12){sign}}, inst_i[31:25], inst_i[11:7]};
    // branch and jump offsets are in half-words, bit 0 stays zero
    assign fmt_b = {{(IMM_W-13){sign}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign fmt_u = {{(IMM_W-32){sign}}, inst_i[31:12], 12'b0};
    assign fmt_j = {{(IMM_W-21){sign}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // one-hot select, no format gives zero
    assign imm_o = ({IMM_W{imm_sel_i[IMM_I]}} & fmt_i)
                 | ({IMM_W{imm_sel_i[IMM_S]}} & fmt_s)
                 | ({IMM_W{imm_sel_i[IMM_B]}} & fmt_b)
                 | ({IMM_W{imm_sel_i[IMM_U]}} & fmt_u)
                 | ({IMM_W{imm_sel_i[IMM_J]}} & fmt_j);

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

    // base widths
    localparam int INST_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 64;

    typedef logic [INST_W-1:0]    inst_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;

    // raw instruction fields
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [11:0] funct12_t;

    // decoded groups, one-hot, bit 0 first in the lists below
    // alu alui aluw aluiw branch jal jalr load store lui auipc sys csr
    typedef logic [12:0] opinfo_t;
    // add sub xor or and sll srl sra slt sltu mul mulh mulhsu mulhu div divu rem remu
    typedef logic [17:0] alu_op_t;
    // beq bne blt bge bltu bgeu
    typedef logic [5:0]  branch_op_t;
    // lb lh lw ld lbu lhu lwu
    typedef logic [6:0]  load_op_t;
    // sb sh sw sd
    typedef logic [3:0]  store_op_t;
    // ebreak ecall mret
    typedef logic [2:0]  sys_op_t;
    // csrrw csrrs
    typedef logic [1:0]  csr_op_t;
    // I S B U J
    typedef logic [4:0]  imm_sel_t;

    // bit positions inside imm_sel_t
    localparam int IMM_I = 0;
    localparam int IMM_S = 1;
    localparam int IMM_B = 2;
    localparam int IMM_U = 3;
    localparam int IMM_J = 4;

    // major opcodes
    localparam opcode_t OP_ALU    = 7'b0110011;
    localparam opcode_t OP_ALUI   = 7'b0010011;
    localparam opcode_t OP_ALUW   = 7'b0111011;
    localparam opcode_t OP_ALUIW  = 7'b0011011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    // funct7 variants
    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;
    localparam funct7_t F7_MULDIV = 7'b0000001;

    // upper field of the privileged system words
    localparam funct12_t F12_ECALL  = 12'h000;
    localparam funct12_t F12_EBREAK = 12'h001;
    localparam funct12_t F12_MRET   = 12'h302;

endpackage

// ==== mem_pkg.sv ====
package mem_pkg;

    localparam int ADDR_W = 64;
    localparam int MASK_W = 8;

    // bytes per fetched instruction word
    localparam int INST_BYTES = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [MASK_W-1:0] mask_t;

    // first fetch address after reset
    localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

    // byte lane masks by access size
    localparam mask_t MASK_BYTE   = 8'h01;
    localparam mask_t MASK_HALF   = 8'h03;
    localparam mask_t MASK_WORD   = 8'h0F;
    localparam mask_t MASK_DOUBLE = 8'hFF;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the decode testbench with Verilator

verilator --binary --timing --top-module tb_decode -f filelist.f -o sim_decode
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    echo "simulation reported errors"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker import isa_pkg::*, mem_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         wb_cyc_i,
    input  logic         wb_stb_i,
    input  logic         wb_we_i,
    input  logic         wb_ack_i,
    input  addr_t        wb_adr_i,
    input  inst_t        wb_dat_i,
    input  logic         valid_i,
    input  logic         ready_i,
    input  addr_t        pc_i,
    // all decoded fields packed, opinfo first and mask last
    input  logic [144:0] dec_i,
    output int           checked_o,
    output int           errors_o
);

    inst_t        word_q[$];
    addr_t        addr_q[$];
    addr_t        exp_pc;
    logic         was_reset = 1'b0;
    logic         hold;
    logic [208:0] held;

    // expected decode, field order as in dec_i
    function automatic logic [144:0] ref_decode(input inst_t w);
        opinfo_t    opi;
        alu_op_t    alu;
        branch_op_t br;
        load_op_t   ld;
        store_op_t  st;
        sys_op_t    sy;
        csr_op_t    cs;
        imm_t       imm;
        mask_t      mask;
        opcode_t    op;
        funct3_t    f3;
        funct7_t    f7;
        logic       is_reg;
        logic       is_imm;
        logic       is_word;
        logic       signed_ld;
        int         idx;
        opi = '0;
        alu = '0;
        br = '0;
        ld = '0;
        st = '0;
        sy = '0;
        cs = '0;
        imm = '0;
        mask = '0;
        signed_ld = 1'b0;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        is_reg = (op == OP_ALU) || (op == OP_ALUW);
        is_imm = (op == OP_ALUI) || (op == OP_ALUIW);
        is_word = (op == OP_ALUW) || (op == OP_ALUIW);
        case (op)
            OP_ALU:    opi[0] = 1'b1;
            OP_ALUI:   opi[1] = 1'b1;
            OP_ALUW:   opi[2] = 1'b1;
            OP_ALUIW:  opi[3] = 1'b1;
            OP_BRANCH: opi[4] = 1'b1;
            OP_JAL:    opi[5] = 1'b1;
            OP_JALR:   opi[6] = 1'b1;
            OP_LOAD:   opi[7] = 1'b1;
            OP_STORE:  opi[8] = 1'b1;
            OP_LUI:    opi[9] = 1'b1;
            OP_AUIPC:  opi[10] = 1'b1;
            OP_SYSTEM: opi[12:11] = 2'b11;
            default:   opi = '0;
        endcase
        // alu bit index, word forms only have add sub and shifts
        idx = -1;
        case (f3)
            3'd0: if (is_imm || f7 == 7'h00) idx = 0; else if (f7 == 7'h20) idx = 1;
            3'd1: if (f7 == 7'h00) idx = 5;
            3'd5: if (f7 == 7'h00) idx = 6; else if (f7 == 7'h20) idx = 7;
            default: begin
                if (!is_word && (is_imm || f7 == 7'h00)) begin
                    idx = (f3 == 3'd2) ? 8 : (f3 == 3'd3) ? 9 : (f3 == 3'd4) ? 2 :
                          (f3 == 3'd6) ? 3 : 4;
                end
            end
        endcase
        if (op == OP_ALU && f7 == 7'h01) idx = 10 + int'(f3);
        if ((is_reg || is_imm) && idx >= 0) alu[idx] = 1'b1;
        if (op == OP_BRANCH) begin
            if (f3 < 3'd2) br[f3] = 1'b1;
            else if (f3 > 3'd3) br[f3 - 3'd2] = 1'b1;
        end
        if (op == OP_LOAD && f3 != 3'd7) begin
            ld[f3] = 1'b1;
            signed_ld = (f3 < 3'd4);
        end
        if (op == OP_STORE && f3 < 3'd4) st[f3] = 1'b1;
        if ((op == OP_LOAD && f3 != 3'd7) || (op == OP_STORE && f3 < 3'd4)) begin
            case (f3[1:0])
                2'd0: mask = MASK_BYTE;
                2'd1: mask = MASK_HALF;
                2'd2: mask = MASK_WORD;
                default: mask = MASK_DOUBLE;
            endcase
        end
        if (op == OP_SYSTEM) begin
            if (f3 == 3'd0 && w[31:20] == 12'h001) sy[0] = 1'b1;
            if (f3 == 3'd0 && w[31:20] == 12'h000) sy[1] = 1'b1;
            if (f3 == 3'd0 && w[31:20] == 12'h302) sy[2] = 1'b1;
            if (f3 == 3'd1) cs[0] = 1'b1;
            if (f3 == 3'd2) cs[1] = 1'b1;
        end
        case (op)
            OP_ALUI, OP_ALUIW, OP_LOAD, OP_JALR, OP_SYSTEM:
                imm = {{52{w[31]}}, w[31:20]};
            OP_STORE:
                imm = {{52{w[31]}}, w[31:25], w[11:7]};
            OP_BRANCH:
                imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {{32{w[31]}}, w[31:12], 12'b0};
            OP_JAL:
                imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: imm = '0;
        endcase
        return {opi, alu, br, ld, st, sy, cs,
                !(op == OP_BRANCH || op == OP_STORE || op == OP_SYSTEM),
                op == OP_SYSTEM, w[11:7], w[19:15], w[24:20], imm,
                signed_ld, op == OP_STORE, op == OP_LOAD, mask};
    endfunction

    always @(posedge clk_i) begin : compare_proc
        logic [144:0] exp;
        inst_t        w;
        addr_t        a;
        if (reset_i) begin
            if (!was_reset) begin
                checked_o = 0;
                errors_o = 0;
            end else if (valid_i !== 1'b0 || wb_cyc_i !== 1'b0 || wb_stb_i !== 1'b0) begin
                $display("valid_o, wb_cyc_o or wb_stb_o is not low during reset");
                errors_o++;
            end
            was_reset = 1'b1;
            hold = 1'b0;
            exp_pc = RESET_PC;
        end else begin
            // fetch bus only ever reads
            if (wb_we_i !== 1'b0) begin
                $display("wb_we_o is not low on the fetch bus");
                errors_o++;
            end
            if (wb_cyc_i && wb_stb_i && wb_ack_i) begin
                word_q.push_back(wb_dat_i);
                addr_q.push_back(wb_adr_i);
            end
            if (hold && (!valid_i || {dec_i, pc_i} !== held)) begin
                $display("outputs changed while ready_i was low");
                errors_o++;
            end
            hold = valid_i && !ready_i;
            held = {dec_i, pc_i};
            if (valid_i && ready_i) begin
                if (word_q.size() == 0) begin
                    $display("output transfer with no fetched word behind it");
                    errors_o++;
                end else begin
                    w = word_q.pop_front();
                    a = addr_q.pop_front();
                    exp = ref_decode(w);
                    if (a !== exp_pc || pc_i !== exp_pc) begin
                        $display("Fail inst %0d word %h pc expected %h actual %h",
                                 checked_o, w, exp_pc, pc_i);
                        errors_o++;
                    end else if (dec_i !== exp) begin
                        $display("Fail inst %0d word %h expected %h actual %h",
                                 checked_o, w, exp, dec_i);
                        errors_o++;
                    end else begin
                        $display("Pass inst %0d word %h pc %h", checked_o, w, pc_i);
                    end
                end
                checked_o++;
                exp_pc = exp_pc + 64'd4;
            end
        end
    end

endmodule

// ==== tb_decode.sv ====
`timescale 1ns/10ps

module tb_decode import isa_pkg::*, mem_pkg::*; ();

    localparam int WORDS = 96;

    logic       clk_i;
    logic       reset_i;
    logic       wb_ack_i;
    inst_t      wb_dat_i;
    logic       ready_i;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    addr_t      wb_adr;
    opinfo_t    opinfo;
    alu_op_t    alu;
    branch_op_t branch;
    load_op_t   load;
    store_op_t  store;
    sys_op_t    sys;
    csr_op_t    csr;
    logic       wen_reg;
    logic       wen_csr;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    imm_t       imm;
    logic       load_signed;
    logic       wen_mem;
    logic       ren_mem;
    mask_t      mask;
    addr_t      pc;
    logic       valid;
    int         checked;
    int         errors;
    inst_t      mem [WORDS];
    int         fill_n;
    int         wait_left;
    logic [31:0] lfsr_q = 32'h8f59_43eb;
    logic [31:0] rnd;

    decode_top i_decode_top (
        .clk_i (clk_i), .reset_i (reset_i),
        .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
        .wb_dat_i (wb_dat_i), .wb_ack_i (wb_ack_i),
        .opinfo_o (opinfo), .alu_o (alu), .branch_o (branch), .load_o (load),
        .store_o (store), .sys_o (sys), .csr_o (csr),
        .wen_reg_o (wen_reg), .wen_csr_o (wen_csr),
        .rd_o (rd), .rs1_o (rs1), .rs2_o (rs2), .imm_o (imm),
        .is_load_signed_o (load_signed), .wen_mem_o (wen_mem), .ren_mem_o (ren_mem),
        .mask_o (mask), .pc_o (pc), .valid_o (valid), .ready_i (ready_i)
    );

    tb_checker i_checker (
        .clk_i (clk_i), .reset_i (reset_i),
        .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_ack_i (wb_ack_i),
        .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_i),
        .valid_i (valid), .ready_i (ready_i), .pc_i (pc),
        .dec_i ({opinfo, alu, branch, load, store, sys, csr, wen_reg, wen_csr,
                 rd, rs1, rs2, imm, load_signed, wen_mem, ren_mem, mask}),
        .checked_o (checked), .errors_o (errors)
    );

    always #2 clk_i = ~clk_i;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] get_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic inst_t enc_r(input funct7_t f7, input funct3_t f3, input opcode_t op);
        return {f7, 5'd3, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic inst_t enc_i(input logic [11:0] i, input funct3_t f3, input opcode_t op);
        return {i, 5'd5, f3, 5'd4, op};
    endfunction

    function automatic inst_t enc_s(input logic [11:0] i, input funct3_t f3);
        return {i[11:5], 5'd7, 5'd6, f3, i[4:0], OP_STORE};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] i, input funct3_t f3);
        return {i[12], i[10:5], 5'd9, 5'd8, f3, i[4:1], i[11], OP_BRANCH};
    endfunction

    function automatic inst_t enc_u(input logic [19:0] i, input opcode_t op);
        return {i, 5'd10, op};
    endfunction

    function automatic inst_t enc_j(input logic [20:0] i);
        return {i[20], i[10:1], i[11], i[19:12], 5'd11, OP_JAL};
    endfunction

    task automatic put(input inst_t w);
        mem[fill_n] = w;
        fill_n++;
    endtask

    // beyond the program the slave returns an address pattern
    function automatic inst_t fetch_word(input addr_t adr);
        addr_t off;
        off = adr - RESET_PC;
        if (off < addr_t'(4 * WORDS)) return mem[off[8:2]];
        return adr[31:0] ^ adr[63:32] ^ 32'h3c5a_96e1;
    endfunction

    task automatic fill_program();
        fill_n = 0;
        for (int f = 0; f < 8; f++) begin
            put(enc_r(F7_BASE, 3'(f), OP_ALU));
            put(enc_r(F7_MULDIV, 3'(f), OP_ALU));
            put(enc_i((f == 1 || f == 5) ? 12'h00d : (f[0] ? 12'h9a3 : 12'h123),
                      3'(f), OP_ALUI));
            if (f < 7) put(enc_i(f[0] ? 12'hff8 : 12'h010, 3'(f), OP_LOAD));
            if (f < 4) put(enc_s(f[0] ? 12'h8a4 : 12'h3fc, 3'(f)));
            if (f < 2 || f > 3) put(enc_b(f[0] ? 13'h1ff0 : 13'h0024, 3'(f)));
        end
        put(enc_r(F7_ALT, 3'd0, OP_ALU));
        put(enc_r(F7_ALT, 3'd5, OP_ALU));
        put(enc_i(12'h40d, 3'd5, OP_ALUI));
        put(enc_r(F7_BASE, 3'd0, OP_ALUW));
        put(enc_r(F7_ALT, 3'd0, OP_ALUW));
        put(enc_r(F7_BASE, 3'd1, OP_ALUW));
        put(enc_r(F7_BASE, 3'd5, OP_ALUW));
        put(enc_r(F7_ALT, 3'd5, OP_ALUW));
        put(enc_i(12'hfff, 3'd0, OP_ALUIW));
        put(enc_i(12'h005, 3'd1, OP_ALUIW));
        put(enc_i(12'h005, 3'd5, OP_ALUIW));
        put(enc_i(12'h405, 3'd5, OP_ALUIW));
        // ecall, ebreak, mret, then two csr forms
        put(32'h0000_0073);
        put(32'h0010_0073);
        put(32'h3020_0073);
        put(enc_i(12'h300, 3'd1, OP_SYSTEM));
        put(enc_i(12'h342, 3'd2, OP_SYSTEM));
        put(enc_j(21'h000800));
        put(enc_j(21'h1ff00c));
        put(enc_i(12'hf00, 3'd0, OP_JALR));
        put(enc_u(20'h8badc, OP_LUI));
        put(enc_u(20'h12345, OP_LUI));
        put(enc_u(20'hfffff, OP_AUIPC));
        while (fill_n < WORDS) begin
            rnd = get_bits(32);
            put(rnd);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        reset_i = 1'b1;
        wb_ack_i = 1'b0;
        wb_dat_i = '0;
        ready_i = 1'b0;
        fill_program();
        rnd = get_bits(2);
        wait_left = int'(rnd);
        repeat (16) @(posedge clk_i);
        #1 reset_i = 1'b0;
        // wishbone slave with 0 to 3 wait states, ready_i stalls
        forever begin
            @(posedge clk_i);
            #1;
            if (wb_ack_i) begin
                wb_ack_i = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (wait_left == 0) begin
                    wb_ack_i = 1'b1;
                    wb_dat_i = fetch_word(wb_adr);
                    rnd = get_bits(2);
                    wait_left = int'(rnd);
                end else begin
                    wait_left--;
                end
            end
            rnd = get_bits(2);
            ready_i = (rnd[1:0] != 2'd0);
        end
    end

    initial begin
        wait (checked == WORDS);
        // away from the edge where the checker updates its counts
        @(negedge clk_i);
        $display("tests %0d errors %0d", checked, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (16 + WORDS * 8 + 100) @(posedge clk_i);
        $display("timeout after %0d of %0d instructions checked", checked, WORDS);
        $display("Finished with errors");
        $finish;
    end

endmodule
